/* bench/fetch_properties.sv */
//--------------------------------------
// fetch unit handshake checks
// icache req/ack hold, decode head
// stability and request state at reset
//--------------------------------------
`timescale 1ns/100ps

module fetch_properties
(
   input  logic                         clk_in,
   input  logic                         reset_in,
   input  logic                         pc_reload,
   input  logic                         ic_reload,
   input  logic                         ic_req,
   input  logic                         ic_ack,
   input  logic [fetch_pkg::pc_sz-1:0]  ic_addr,
   input  logic                         f2d_valid,
   input  logic                         f2d_ready,
   input  logic [fetch_pkg::xlen-1:0]   f2d_instr,
   input  logic [fetch_pkg::pc_sz-1:0]  f2d_pc,
   input  logic [fetch_pkg::pc_sz-1:0]  f2d_pred_addr
);

   int unsigned fail_count = 0;                    // assertion failures so far

   // request stays up with a steady address until the cache answers
   req_hold_a: assert property (@(posedge clk_in) disable iff (reset_in)
      ic_req && !ic_ack |=> ic_req && $stable(ic_addr))
      else
      begin
         $error("ic_req dropped or ic_addr moved before ic_ack");
         fail_count = fail_count + 1;
      end

   req_drop_a: assert property (@(posedge clk_in) disable iff (reset_in)
      ic_req && ic_ack |=> !ic_req)
      else
      begin
         $error("ic_req still high after the line transfer");
         fail_count = fail_count + 1;
      end

   // stalled head must not move, a reload may replace it
   head_stable_a: assert property (@(posedge clk_in) disable iff (reset_in)
      f2d_valid && !f2d_ready && !(pc_reload || ic_reload) |=>
         f2d_valid && $stable(f2d_instr) && $stable(f2d_pc) && $stable(f2d_pred_addr))
      else
      begin
         $error("decode head changed while stalled");
         fail_count = fail_count + 1;
      end

   reset_req_a: assert property (@(posedge clk_in)
      $fell(reset_in) |-> !ic_req)
      else
      begin
         $error("ic_req high in the first cycle after reset");
         fail_count = fail_count + 1;
      end

endmodule

bind fetch_top fetch_properties u_props (
   .clk_in(clk_in), .reset_in(reset_in), .pc_reload(pc_reload), .ic_reload(ic_reload),
   .ic_req(ic_req), .ic_ack(ic_ack), .ic_addr(ic_addr),
   .f2d_valid(f2d_valid), .f2d_ready(f2d_ready), .f2d_instr(f2d_instr),
   .f2d_pc(f2d_pc), .f2d_pred_addr(f2d_pred_addr)
);

/* bench/fetch_tb.sv */
//--------------------------------------
// fetch unit testbench
// icache model with random latency,
// program images, reference model of
// the predicted stream, checks on decode
//--------------------------------------
`timescale 1ns/100ps

module fetch_tb;
   import fetch_pkg::*;

   logic                 clk_in;
   logic                 reset_in;
   logic                 cpu_halt;
   logic                 pc_reload;
   logic                 ic_reload;
   logic [pc_sz-1:0]     pc_reload_addr;
   logic                 ic_req;
   logic [pc_sz-1:0]     ic_addr;
   logic                 ic_ack;
   logic [line_bits-1:0] ic_data;
   logic                 f2d_valid;
   logic                 f2d_ready;
   logic [xlen-1:0]      f2d_instr;
   logic [pc_sz-1:0]     f2d_pc;
   logic [pc_sz-1:0]     f2d_pred_addr;

   logic [xlen-1:0]      mem [1024];        // 4 KB image, upper address bits alias
   logic [pc_sz-1:0]     m_pc;              // model pc
   logic [pc_sz-1:0]     m_ras [ras_depth];
   logic [2:0]           m_sp;              // wraps like the real stack
   logic                 busy;              // cache has seen the request
   logic [1:0]           delay;
   int                   ready_mode;        // 0 always ready, 1 random, 2 held low
   int                   stall_left;
   int                   checked;

   fetch_top DUT (.*);

   always #20 clk_in = ~clk_in;

   //--------------------------------------
   // failure reporting and compares
   //--------------------------------------
   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("SIMULATION FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_instr(input logic [xlen-1:0] got, input logic [xlen-1:0] exp);
      if (got !== exp)
         report_failure($sformatf("ERR %0t ns: instruction %h, expected %h", $time, got, exp));
   endtask

   task automatic check_pc(input logic [pc_sz-1:0] got, input logic [pc_sz-1:0] exp);
      if (got !== exp)
         report_failure($sformatf("ERR %0t ns: pc %h, expected %h", $time, got, exp));
   endtask

   task automatic check_pred(input logic [pc_sz-1:0] got, input logic [pc_sz-1:0] exp);
      if (got !== exp)
         report_failure($sformatf("ERR %0t ns: predicted addr %h, expected %h",
                                  $time, got, exp));
   endtask

   // handshake assertions from the bound checker
   always @(DUT.u_props.fail_count)
   begin
      if (DUT.u_props.fail_count != 0)
         report_failure("a handshake assertion failed in the bound checker");
   end

   //--------------------------------------
   // reference model, one stream position per call
   //--------------------------------------
   function automatic void expect_next(output logic [xlen-1:0] e_instr,
                                       output logic [pc_sz-1:0] e_pc,
                                       output logic [pc_sz-1:0] e_pred);
      logic [xlen-1:0]  w;
      logic [pc_sz-1:0] seq;
      logic [pc_sz-1:0] ii;
      logic [pc_sz-1:0] bi;
      logic [pc_sz-1:0] ji;
      logic             lrd;
      logic             lrs;
      w    = mem[m_pc[11:2]];
      seq  = m_pc + 32'd4;
      ii   = {{20{w[31]}}, w[31:20]};
      bi   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      ji   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      lrd  = (w[11:7] == 5'd1) || (w[11:7] == 5'd5);
      lrs  = (w[19:15] == 5'd1) || (w[19:15] == 5'd5);
      e_pc    = m_pc;
      e_instr = (w[1:0] != 2'b11) ? {16'h0000, w[15:0]} : w;   // 16 bit keeps low half
      e_pred  = seq;
      if ((w[1:0] == 2'b11) && (w[4:2] != 3'b111))
      begin
         if (w == 32'h3020_0073)
         begin
            e_pred = m_ras[m_sp - 3'd1];                        // mret returns via stack
            m_sp   = m_sp - 3'd1;
         end
         else if ((w == 32'h0000_0073) || (w == 32'h0010_0073))
            e_pred = '0;
         else if (w[6:0] == 7'h6f)
         begin
            e_pred = m_pc + ji;
            if (lrd)
            begin
               m_ras[m_sp] = seq;
               m_sp        = m_sp + 3'd1;
            end
         end
         else if ((w[6:0] == 7'h67) && (w[14:12] == 3'b000))
         begin
            e_pred = ii;                                        // target from imm only
            if (lrd && lrs && (w[19:15] != w[11:7]))
               m_ras[m_sp - 3'd1] = seq;
            else if (lrd)
            begin
               m_ras[m_sp] = seq;
               m_sp        = m_sp + 3'd1;
            end
            else if (lrs)
               m_sp = m_sp - 3'd1;
         end
         else if (w[6:0] == 7'h63)
            e_pred = bi[31] ? m_pc + bi : seq;                  // backward taken
      end
      m_pc = e_pred;
   endfunction

   always @(negedge clk_in)
   begin : compare_outputs
      logic [xlen-1:0]  e_instr;
      logic [pc_sz-1:0] e_pc;
      logic [pc_sz-1:0] e_pred;
      if (!reset_in && f2d_valid && f2d_ready)
      begin
         expect_next(e_instr, e_pc, e_pred);
         check_instr(f2d_instr, e_instr);
         check_pc(f2d_pc, e_pc);
         check_pred(f2d_pred_addr, e_pred);
         checked = checked + 1;
      end
   end

   //--------------------------------------
   // icache model and decode ready
   //--------------------------------------
   function automatic logic [line_bits-1:0] line_at(input logic [pc_sz-1:0] a);
      logic [line_bits-1:0] l;
      for (int k = 0; k < instr_per_line; k++)
         l[k*xlen +: xlen] = mem[{a[11:5], 3'(k)}];
      return l;
   endfunction

   always @(posedge clk_in)
   begin
      if (reset_in || ic_ack)
      begin
         ic_ack <= 1'b0;
         busy   <= 1'b0;
      end
      else if (ic_req)
      begin
         if (!busy)
         begin
            busy  <= 1'b1;
            delay <= 2'($urandom % 4);                          // 0..3 extra cycles
         end
         else if (delay == 2'd0)
         begin
            ic_ack  <= 1'b1;
            ic_data <= line_at(ic_addr);
         end
         else
            delay <= delay - 2'd1;
      end
   end

   always @(posedge clk_in)
   begin
      if (ready_mode == 0)
         f2d_ready <= 1'b1;
      else if (ready_mode == 2)
         f2d_ready <= 1'b0;
      else if (stall_left != 0)
      begin
         f2d_ready  <= 1'b0;
         stall_left <= stall_left - 1;
      end
      else if (($urandom % 40) == 0)
      begin
         f2d_ready  <= 1'b0;
         stall_left <= 24 + ($urandom % 16);                    // long enough to fill queue
      end
      else
         f2d_ready <= (($urandom % 4) != 0);
   end

   //--------------------------------------
   // program images
   //--------------------------------------
   function automatic logic [xlen-1:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
      return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
   endfunction

   function automatic logic [xlen-1:0] branch_word(input logic [2:0] f3, input logic [12:0] off);
      return {off[12], off[10:5], 5'd2, 5'd0, f3, off[4:1], off[11], 7'h63};
   endfunction

   function automatic logic [xlen-1:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'h67};
   endfunction

   task automatic build_programs;
      for (int i = 0; i < 1024; i++)
         mem[i] = {2'b01, 10'(i), 5'd2, 3'b000, 5'd3, 7'h13};   // addi x3, x2, index
      mem['h110 >> 2] = 32'h1234_4501;                          // 16 bit encoding
      mem['h118 >> 2] = 32'h0000_001f;                          // 48 bit encoding
      mem['h120 >> 2] = branch_word(3'b001, 13'h010);           // forward, not taken
      mem['h140 >> 2] = jal_word(5'd1, 21'h0c0);                // call 0x200
      mem['h208 >> 2] = jal_word(5'd0, 21'h0f0);                // to 0x2f8
      mem['h2f0 >> 2] = jal_word(5'd0, 21'h110);                // to 0x400
      mem['h300 >> 2] = branch_word(3'b000, -13'd16);           // back to 0x2f0
      mem['h410 >> 2] = 32'h3020_0073;                          // mret to 0x144
      mem['h150 >> 2] = jal_word(5'd1, 21'h3b0);                // call 0x500
      mem['h50c >> 2] = jalr_word(5'd0, 5'd1, 12'h154);         // return through x1
      mem['h15c >> 2] = jalr_word(5'd1, 5'd0, 12'h600);         // push 0x160
      mem['h608 >> 2] = jalr_word(5'd1, 5'd5, 12'h700);         // pop then push 0x60c
      mem['h700 >> 2] = 32'h3020_0073;                          // mret to 0x60c
      mem['h614 >> 2] = 32'h0000_0073;                          // ecall, on to 0x000
      // stack free loops for the reload runs
      mem['h820 >> 2] = branch_word(3'b001, 13'h008);
      mem['h83c >> 2] = branch_word(3'b000, -13'd60);           // back to 0x800
      mem['h910 >> 2] = jal_word(5'd0, 21'h030);                // to 0x940
      mem['h95c >> 2] = branch_word(3'b100, -13'd92);           // back to 0x900
   endtask

   //--------------------------------------
   // sequencing helpers
   //--------------------------------------
   task automatic wait_outputs(input int n, input int limit);
      int target;
      int cyc;
      target = checked + n;
      cyc    = 0;
      while (checked < target)
      begin
         @(posedge clk_in);
         cyc = cyc + 1;
         if (cyc > limit)
            report_failure($sformatf("timed out after %0d cycles waiting for %0d outputs",
                                     limit, n));
      end
   endtask

   task automatic set_ready_mode(input int m);
      @(negedge clk_in);
      ready_mode = m;                                           // picked up at next edge
   endtask

   task automatic do_reload(input logic [pc_sz-1:0] addr, input logic use_ic);
      set_ready_mode(2);
      @(posedge clk_in);
      pc_reload      <= !use_ic;
      ic_reload      <= use_ic;
      pc_reload_addr <= addr;
      @(posedge clk_in);
      pc_reload <= 1'b0;
      ic_reload <= 1'b0;
      m_pc = addr;                                              // model restarts here
      set_ready_mode(0);
   endtask

   task automatic hold_halt;
      @(posedge clk_in);
      cpu_halt <= 1'b1;
      repeat (20) @(posedge clk_in);                            // queue drains meanwhile
      repeat (40)
      begin
         @(negedge clk_in);
         if (f2d_valid)
            report_failure("a new entry reached decode while cpu_halt was high");
      end
      @(posedge clk_in);
      cpu_halt <= 1'b0;
   endtask

   initial
   begin
      void'($urandom(32'hc7b9_0747));
      clk_in         = 1'b0;
      reset_in       <= 1'b1;
      cpu_halt       <= 1'b0;
      pc_reload      <= 1'b0;
      ic_reload      <= 1'b0;
      pc_reload_addr <= '0;
      ic_ack         <= 1'b0;
      ic_data        <= '0;
      f2d_ready      <= 1'b0;
      ready_mode     = 0;
      stall_left     = 0;
      checked        = 0;
      m_pc           = reset_vector;
      m_sp           = '0;
      for (int e = 0; e < ras_depth; e++)
         m_ras[e] = '0;
      build_programs();
      repeat (16) @(posedge clk_in);
      reset_in <= 1'b0;

      wait_outputs(300, 4000);                                  // code, branches, calls
      set_ready_mode(1);
      wait_outputs(400, 20000);                                 // back-pressure
      set_ready_mode(0);
      hold_halt();
      wait_outputs(150, 3000);
      do_reload(32'h0000_0800, 1'b0);
      wait_outputs(100, 2000);
      do_reload(32'h0000_0900, 1'b1);
      wait_outputs(100, 2000);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

/* filelist.f */
source/fetch_pkg.sv
source/fetch_control.sv
source/line_predecode.sv
source/return_stack.sv
source/instr_queue.sv
source/fetch_top.sv
bench/fetch_properties.sv
bench/fetch_tb.sv

/* source/fetch_control.sv */
//--------------------------------------
// fetch control
// request FSM towards the instruction
// cache, pc, reload capture and the
// next fetch address
//--------------------------------------
`timescale 1ns/100ps

module fetch_control
(
   input  logic                         clk_in,
   input  logic                         reset_in,
   input  logic                         cpu_halt,          // hold off, line gets refetched
   input  logic                         pc_reload,         // mispredict from later stage
   input  logic                         ic_reload,         // store hit the icache space
   input  logic [fetch_pkg::pc_sz-1:0]  pc_reload_addr,
   input  logic                         ic_ack,
   input  logic                         queue_full,
   input  logic [fetch_pkg::pc_sz-1:0]  last_pred_addr,    // from predecode
   output logic                         ic_req,
   output logic [fetch_pkg::pc_sz-1:0]  ic_addr,
   output logic [fetch_pkg::pc_sz-1:0]  pc,
   output logic                         line_accept,
   output logic                         flush
);
   import fetch_pkg::*;

   fetch_state_t     state;
   logic             reload_flag;                          // reload seen, not yet refetched
   logic [pc_sz-1:0] reload_addr;                          // newest reload target
   logic [pc_sz-1:0] lpa;                                  // last predicted address
   logic             xfer;                                 // line moves this cycle

   assign xfer    = ic_req & ic_ack;
   assign flush   = pc_reload | ic_reload;
   assign ic_addr = pc;                                    // held stable while req is high

   // a line fetched before the reload is thrown away, only the
   // reload acknowledge line is kept
   assign line_accept = xfer & !cpu_halt & !flush &
                        (!reload_flag | (state == FETCH_RELOAD_ACK));

   //--------------------------------------
   // request FSM
   //--------------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         state       <= FETCH_IDLE;
         ic_req      <= 1'b0;
         pc          <= reset_vector;
         lpa         <= reset_vector;
         reload_flag <= 1'b0;
      end
      else
      begin
         case (state)
            FETCH_IDLE:
            begin
               if (!queue_full && !ic_reload)
               begin
                  ic_req <= 1'b1;
                  pc     <= reload_flag ? reload_addr : lpa;
                  // a reload arriving now makes this address stale
                  state  <= (reload_flag && !flush) ? FETCH_RELOAD_ACK : FETCH_ACK;
               end
            end
            default:                                       // both ack states
            begin
               if (xfer)
               begin
                  ic_req <= 1'b0;
                  lpa    <= last_pred_addr;                // pc itself when nothing kept
                  state  <= FETCH_IDLE;
               end
               else if (flush)
                  state  <= FETCH_ACK;                     // newer reload, drop this line
            end
         endcase

         if (flush)
            reload_flag <= 1'b1;                           // set wins over clear
         else if (xfer && (state == FETCH_RELOAD_ACK))
            reload_flag <= 1'b0;
      end

      if (flush)
         reload_addr <= pc_reload_addr;                    // newest address wins
   end

endmodule

/* source/fetch_pkg.sv */
//--------------------------------------
// fetch unit definitions
// cache line geometry, queue and stack
// sizes, reset vector and the enums
// shared by the fetch blocks
//--------------------------------------
package fetch_pkg;

   //--------------------------------------
   // address and line geometry
   //--------------------------------------
   localparam int pc_sz          = 32;        // pc / address width
   localparam int xlen           = 32;        // instruction word width
   localparam int line_bytes     = 32;        // bytes per cache line
   localparam int line_bits      = line_bytes * 8;
   localparam int instr_per_line = 8;         // 32 bit slots per line
   localparam int offset_sz      = 5;         // byte offset inside a line

   //--------------------------------------
   // queue and return stack
   //--------------------------------------
   localparam int queue_depth    = 2 * instr_per_line;
   localparam int queue_ptr_sz   = 4;
   localparam int queue_cnt_sz   = 5;         // count runs 0..queue_depth
   localparam int ras_depth      = 8;
   localparam int ras_ptr_sz     = 3;         // wraps, no overflow check

   // first fetch address out of reset
   localparam logic [pc_sz-1:0] reset_vector = 32'h0000_0100;

   // request FSM
   typedef enum logic [1:0] {
      FETCH_IDLE,                             // decide whether to request
      FETCH_ACK,                              // normal line outstanding
      FETCH_RELOAD_ACK                        // line for a reload address outstanding
   } fetch_state_t;

   // predecode classes
   typedef enum logic [2:0] {
      BR_NONE,
      BR_JALR,
      BR_COND,
      BR_JAL,
      BR_RET,                                 // mret
      BR_TRAP                                 // ecall / ebreak
   } branch_kind_t;

   // return stack operations, at most one per line
   typedef enum logic [1:0] {
      RAS_NONE,
      RAS_POP,
      RAS_PUSH,
      RAS_POP_PUSH
   } ras_op_t;

endpackage

/* source/fetch_top.sv */
//--------------------------------------
// fetch unit top
// instruction cache port in, decode
// port out, control plus datapath
//--------------------------------------
`timescale 1ns/100ps

module fetch_top
(
   input  logic                             clk_in,
   input  logic                             reset_in,
   input  logic                             cpu_halt,
   input  logic                             pc_reload,
   input  logic                             ic_reload,
   input  logic [fetch_pkg::pc_sz-1:0]      pc_reload_addr,
   output logic                             ic_req,        // icache req/ack
   output logic [fetch_pkg::pc_sz-1:0]      ic_addr,
   input  logic                             ic_ack,
   input  logic [fetch_pkg::line_bits-1:0]  ic_data,
   output logic                             f2d_valid,     // decode valid/ready
   input  logic                             f2d_ready,
   output logic [fetch_pkg::xlen-1:0]       f2d_instr,
   output logic [fetch_pkg::pc_sz-1:0]      f2d_pc,
   output logic [fetch_pkg::pc_sz-1:0]      f2d_pred_addr
);
   import fetch_pkg::*;

   logic [pc_sz-1:0]                         pc;
   logic                                     line_accept;
   logic                                     flush;
   logic                                     queue_full;
   logic [pc_sz-1:0]                         last_pred_addr;
   logic [queue_cnt_sz-1:0]                  free_slots;
   logic [queue_cnt_sz-1:0]                  write_count;
   logic [instr_per_line-1:0][xlen-1:0]      slot_instr;
   logic [instr_per_line-1:0][pc_sz-1:0]     slot_pc;
   logic [instr_per_line-1:0][pc_sz-1:0]     slot_pred;
   ras_op_t                                  ras_op;
   logic [pc_sz-1:0]                         push_addr;
   logic [pc_sz-1:0]                         ras_top;

   fetch_control u_control (
      .clk_in(clk_in), .reset_in(reset_in), .cpu_halt(cpu_halt),
      .pc_reload(pc_reload), .ic_reload(ic_reload), .pc_reload_addr(pc_reload_addr),
      .ic_ack(ic_ack), .queue_full(queue_full), .last_pred_addr(last_pred_addr),
      .ic_req(ic_req), .ic_addr(ic_addr), .pc(pc),
      .line_accept(line_accept), .flush(flush)
   );

   line_predecode u_predecode (
      .ic_data(ic_data), .pc(pc), .line_accept(line_accept),
      .free_slots(free_slots), .ras_top(ras_top),
      .slot_instr(slot_instr), .slot_pc(slot_pc), .slot_pred(slot_pred),
      .write_count(write_count), .last_pred_addr(last_pred_addr),
      .ras_op(ras_op), .push_addr(push_addr)
   );

   return_stack u_ras (
      .clk_in(clk_in), .reset_in(reset_in), .ras_op(ras_op),
      .push_addr(push_addr), .line_accept(line_accept), .ras_top(ras_top)
   );

   instr_queue u_queue (
      .clk_in(clk_in), .reset_in(reset_in), .flush(flush),
      .slot_instr(slot_instr), .slot_pc(slot_pc), .slot_pred(slot_pred),
      .write_count(write_count), .f2d_ready(f2d_ready),
      .free_slots(free_slots), .queue_full(queue_full),
      .f2d_valid(f2d_valid), .f2d_instr(f2d_instr),
      .f2d_pc(f2d_pc), .f2d_pred_addr(f2d_pred_addr)
   );

endmodule

/* source/instr_queue.sv */
//--------------------------------------
// instruction queue
// 16 entry circular buffer, up to a
// line's worth written per cycle, one
// entry read towards decode
//--------------------------------------
`timescale 1ns/100ps

module instr_queue
(
   input  logic                                clk_in,
   input  logic                                reset_in,
   input  logic                                flush,
   input  logic [fetch_pkg::instr_per_line-1:0][fetch_pkg::xlen-1:0]  slot_instr,
   input  logic [fetch_pkg::instr_per_line-1:0][fetch_pkg::pc_sz-1:0] slot_pc,
   input  logic [fetch_pkg::instr_per_line-1:0][fetch_pkg::pc_sz-1:0] slot_pred,
   input  logic [fetch_pkg::queue_cnt_sz-1:0]  write_count,
   input  logic                                f2d_ready,
   output logic [fetch_pkg::queue_cnt_sz-1:0]  free_slots,
   output logic                                queue_full,
   output logic                                f2d_valid,
   output logic [fetch_pkg::xlen-1:0]          f2d_instr,
   output logic [fetch_pkg::pc_sz-1:0]         f2d_pc,
   output logic [fetch_pkg::pc_sz-1:0]         f2d_pred_addr
);
   import fetch_pkg::*;

   logic [xlen-1:0]         q_instr [queue_depth];
   logic [pc_sz-1:0]        q_pc    [queue_depth];
   logic [pc_sz-1:0]        q_pred  [queue_depth];
   logic [queue_ptr_sz-1:0] wr_ptr;                // input pointer, wraps
   logic [queue_ptr_sz-1:0] rd_ptr;                // head
   logic [queue_cnt_sz-1:0] count;
   logic                    rd_xfer;               // head leaves this cycle

   assign f2d_valid     = (count != '0);
   assign rd_xfer       = f2d_valid & f2d_ready;
   assign queue_full    = (count == queue_cnt_sz'(queue_depth));
   assign free_slots    = queue_cnt_sz'(queue_depth) - count;
   assign f2d_instr     = q_instr[rd_ptr];
   assign f2d_pc        = q_pc[rd_ptr];
   assign f2d_pred_addr = q_pred[rd_ptr];

   //--------------------------------------
   // entry storage
   //--------------------------------------
   always_ff @(posedge clk_in)
   begin
      for (int c = 0; c < instr_per_line; c++)
      begin
         if (c < write_count)
         begin
            q_instr[wr_ptr + queue_ptr_sz'(c)] <= slot_instr[c];
            q_pc[wr_ptr + queue_ptr_sz'(c)]    <= slot_pc[c];
            q_pred[wr_ptr + queue_ptr_sz'(c)]  <= slot_pred[c];
         end
      end
   end

   // pointers and count, flush drops whatever is in flight
   always_ff @(posedge clk_in)
   begin
      if (reset_in | flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         wr_ptr <= wr_ptr + queue_ptr_sz'(write_count);
         if (rd_xfer)
            rd_ptr <= rd_ptr + 1'b1;
         count  <= count + write_count - queue_cnt_sz'(rd_xfer);  // write and read together
      end
   end

endmodule

/* source/line_predecode.sv */
//--------------------------------------
// line predecode
// walks an accepted cache line from the
// pc offset, classifies each word, works
// out its predicted next address and the
// return stack operation for the line
//--------------------------------------
`timescale 1ns/100ps

module line_predecode
(
   input  logic [fetch_pkg::line_bits-1:0]     ic_data,
   input  logic [fetch_pkg::pc_sz-1:0]         pc,
   input  logic                                line_accept,
   input  logic [fetch_pkg::queue_cnt_sz-1:0]  free_slots,
   input  logic [fetch_pkg::pc_sz-1:0]         ras_top,
   output logic [fetch_pkg::instr_per_line-1:0][fetch_pkg::xlen-1:0]  slot_instr,
   output logic [fetch_pkg::instr_per_line-1:0][fetch_pkg::pc_sz-1:0] slot_pc,
   output logic [fetch_pkg::instr_per_line-1:0][fetch_pkg::pc_sz-1:0] slot_pred,
   output logic [fetch_pkg::queue_cnt_sz-1:0]  write_count,
   output logic [fetch_pkg::pc_sz-1:0]         last_pred_addr,
   output fetch_pkg::ras_op_t                  ras_op,
   output logic [fetch_pkg::pc_sz-1:0]         push_addr
);
   import fetch_pkg::*;

   logic [offset_sz-2:0] slot_idx;                  // word slot inside the line, 8 = past end
   logic [xlen-1:0]      word;                      // raw word at slot_idx
   logic [xlen-1:0]      instr;                     // what goes into the queue
   logic [pc_sz-1:0]     addr;                      // pc of the current word
   logic [pc_sz-1:0]     seq_addr;
   logic [pc_sz-1:0]     pred;
   logic [pc_sz-1:0]     i_imm;
   logic [pc_sz-1:0]     b_imm;
   logic [pc_sz-1:0]     j_imm;
   logic [4:0]           rd;
   logic [4:0]           rs1;
   logic                 link_rd;
   logic                 link_rs1;
   logic                 is32;
   logic                 taken;
   logic                 done;
   branch_kind_t         kind;

   always_comb
   begin
      slot_instr     = '0;
      slot_pc        = '0;
      slot_pred      = '0;
      write_count    = '0;
      last_pred_addr = pc;                          // nothing kept -> same pc again
      ras_op         = RAS_NONE;
      push_addr      = '0;
      addr           = pc;
      slot_idx       = '0;
      word           = '0;
      instr          = '0;
      seq_addr       = '0;
      pred           = '0;
      i_imm          = '0;
      b_imm          = '0;
      j_imm          = '0;
      rd             = '0;
      rs1            = '0;
      link_rd        = 1'b0;
      link_rs1       = 1'b0;
      is32           = 1'b0;
      taken          = 1'b0;
      kind           = BR_NONE;
      done           = !line_accept;                // no line, no work

      for (int c = 0; c < instr_per_line; c++)
      begin
         slot_idx = {1'b0, pc[offset_sz-1:2]} + (offset_sz-1)'(c);
         if (!done && (slot_idx < instr_per_line) && (write_count < free_slots))
         begin
            word     = ic_data[slot_idx*xlen +: xlen];
            is32     = (word[1:0] == 2'b11) && (word[4:2] != 3'b111);
            instr    = (word[1:0] != 2'b11) ? {16'b0, word[15:0]} : word;  // 48 bit keeps low 32

            // immediates, sign extended
            i_imm    = {{20{word[31]}}, word[31:20]};
            b_imm    = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
            j_imm    = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
            rd       = word[11:7];
            rs1      = word[19:15];
            link_rd  = (rd == 5'd1) || (rd == 5'd5);   // x1 / x5 are link regs
            link_rs1 = (rs1 == 5'd1) || (rs1 == 5'd5);
            seq_addr = addr + pc_sz'(4);

            //--------------------------------------
            // classify
            //--------------------------------------
            kind = BR_NONE;
            if (is32)
            begin
               case (word[6:2])
                  5'b11000: kind = BR_COND;        // beq .. bgeu
                  5'b11001: kind = (word[14:12] == 3'b000) ? BR_JALR : BR_NONE;
                  5'b11011: kind = BR_JAL;
                  default:  kind = BR_NONE;
               endcase
               if (word == 32'h3020_0073)
                  kind = BR_RET;                   // mret
               if ((word == 32'h0000_0073) || (word == 32'h0010_0073))
                  kind = BR_TRAP;                  // ecall, ebreak
            end

            //--------------------------------------
            // predicted address
            //--------------------------------------
            case (kind)
               BR_JAL:  pred = addr + j_imm;
               BR_COND: pred = b_imm[31] ? addr + b_imm : seq_addr;  // backward taken guess
               BR_JALR: pred = i_imm;               // assumes rs1 = x0
               BR_RET:  pred = ras_top;
               BR_TRAP: pred = '0;                  // trap vector not known here
               default: pred = seq_addr;
            endcase
            taken = (kind != BR_NONE) && !((kind == BR_COND) && !b_imm[31]);

            // stack op, every one of these also ends the line
            if ((kind == BR_JAL) && link_rd)
            begin
               ras_op    = RAS_PUSH;
               push_addr = seq_addr;
            end
            if (kind == BR_JALR)
            begin
               push_addr = seq_addr;
               case ({link_rd, link_rs1})
                  2'b01:   ras_op = RAS_POP;
                  2'b10:   ras_op = RAS_PUSH;
                  2'b11:   ras_op = (rs1 == rd) ? RAS_PUSH : RAS_POP_PUSH;
                  default: ras_op = RAS_NONE;
               endcase
            end
            if (kind == BR_RET)
               ras_op = RAS_POP;

            // kept slots are consecutive from 0
            slot_instr[c]  = instr;
            slot_pc[c]     = addr;
            slot_pred[c]   = pred;
            write_count    = write_count + 1'b1;
            last_pred_addr = pred;
            addr           = seq_addr;
            done           = taken || !is32;        // 16/48 bit stops the line too
         end
      end
   end

endmodule

/* source/return_stack.sv */
//--------------------------------------
// return address stack
// 8 entries with a wrapping pointer,
// one operation per accepted line
//--------------------------------------
`timescale 1ns/100ps

module return_stack
(
   input  logic                         clk_in,
   input  logic                         reset_in,
   input  fetch_pkg::ras_op_t           ras_op,
   input  logic [fetch_pkg::pc_sz-1:0]  push_addr,
   input  logic                         line_accept,
   output logic [fetch_pkg::pc_sz-1:0]  ras_top
);
   import fetch_pkg::*;

   logic [pc_sz-1:0]      ras_mem [ras_depth];
   logic [ras_ptr_sz-1:0] ras_ptr;                 // next free entry
   logic [ras_ptr_sz-1:0] below_ptr;               // most recent entry

   assign below_ptr = ras_ptr - 1'b1;              // wraps
   assign ras_top   = ras_mem[below_ptr];

   always_ff @(posedge clk_in)
   begin
      if (reset_in)
      begin
         ras_ptr <= '0;
         for (int e = 0; e < ras_depth; e++)
            ras_mem[e] <= '0;
      end
      else if (line_accept)
      begin
         case (ras_op)
            RAS_POP:      ras_ptr <= below_ptr;
            RAS_PUSH:
            begin
               ras_mem[ras_ptr] <= push_addr;
               ras_ptr          <= ras_ptr + 1'b1;
            end
            RAS_POP_PUSH: ras_mem[below_ptr] <= push_addr;   // replace top, ptr stays
            default:      ras_ptr <= ras_ptr;
         endcase
      end
   end

endmodule
